// File: src.f
rtl/plic_pkg.sv
rtl/plic_apb_regs.sv
rtl/plic_gateway.sv
rtl/plic_arbiter.sv
rtl/plic_target.sv
rtl/plic_top.sv
tb/plic_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the interrupt controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module plic_tb -Mdir "$BUILD_DIR" -o plic_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/plic_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

// File: tb/plic_tb.sv
/*
  Testbench for plic_top with 31 sources. A table of APB accesses, source
  strobes and interrupt line checks is built first, then applied in order.
  Inputs change 1 ns after the rising edge, outputs are sampled 1 ns
  before the next one. Every wait gives up after a fixed number of cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module plic_tb import plic_pkg::*; ();

    localparam int NUM_SRC     = 31;
    localparam int APB_TIMEOUT = 16;
    localparam int IRQ_TIMEOUT = 20;

    localparam int OP_WRITE  = 0;
    localparam int OP_READ   = 1;
    localparam int OP_STROBE = 2;
    localparam int OP_IRQ    = 3;
    localparam int OP_IDLE   = 4;
    localparam int OP_TRAP   = 5;
    localparam int OP_END    = 6;

    logic             PCLK;
    logic             PRESETn;
    logic [NUM_SRC:1] irq_src;
    logic             trap_en;
    logic             PSEL;
    logic             PENABLE;
    logic             PWRITE;
    logic [31:0]      PADDR;
    logic [31:0]      PWDATA;
    wire  [31:0]      PRDATA;
    wire              PREADY;
    wire              PSLVERR;
    wire              irq_out;
    wire              irq_external_pending;

    // Stimulus table, one entry per index
    int          op_q   [$];
    logic [31:0] addr_q [$];
    logic [31:0] data_q [$];
    logic [31:0] exp_q  [$];
    logic        err_q  [$];
    string       name_q [$];

    int     errors;
    int     checks;
    bit     bus_stuck;
    integer seed;

    plic_top #(.NUM_SRC(NUM_SRC)) DUT (
        .PCLK                 (PCLK),
        .PRESETn              (PRESETn),
        .irq_src              (irq_src),
        .trap_en              (trap_en),
        .irq_out              (irq_out),
        .irq_external_pending (irq_external_pending),
        .PSEL                 (PSEL),
        .PENABLE              (PENABLE),
        .PWRITE               (PWRITE),
        .PADDR                (PADDR),
        .PWDATA               (PWDATA),
        .PRDATA               (PRDATA),
        .PREADY               (PREADY),
        .PSLVERR              (PSLVERR)
    );

    initial PCLK = 1'b0;
    always #2 PCLK = ~PCLK;

    function automatic logic [31:0] prio_addr(input int id);
        return ADDR_PRIO_BASE + 32'(4 * id);
    endfunction

    function automatic logic [31:0] bit_of(input int id);
        return 32'h1 << id;
    endfunction

    task automatic add_step(input int op, input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] expv, input logic err);
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        exp_q.push_back(expv);
        err_q.push_back(err);
    endtask

    task automatic queue_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic err);
        add_step(OP_WRITE, addr, data, 32'h0, err);
    endtask

    task automatic expect_read(input logic [31:0] addr, input logic [31:0] expv,
                               input logic err);
        add_step(OP_READ, addr, 32'h0, expv, err);
    endtask

    task automatic strobe_src(input logic [31:0] mask);
        add_step(OP_STROBE, 32'h0, mask, 32'h0, 1'b0);
    endtask

    task automatic expect_irq(input logic out, input logic ext);
        add_step(OP_IRQ, 32'h0, 32'h0, {30'h0, ext, out}, 1'b0);
    endtask

    task automatic wait_cycles(input int n);
        add_step(OP_IDLE, 32'h0, 32'(n), 32'h0, 1'b0);
    endtask

    task automatic set_trap(input logic v);
        add_step(OP_TRAP, 32'h0, {31'h0, v}, 32'h0, 1'b0);
    endtask

    task automatic close_test(input string name);
        add_step(OP_END, 32'h0, 32'(name_q.size()), 32'h0, 1'b0);
        name_q.push_back(name);
    endtask

    // One APB transfer, setup then access; read data sampled late in the access cycle
    task automatic apb_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        waited  = 0;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = write;
        PADDR   = addr;
        PWDATA  = wdata;
        @(posedge PCLK);
        #1;
        PENABLE = 1'b1;
        #2;
        while (!PREADY && waited < APB_TIMEOUT) begin
            @(posedge PCLK);
            #3;
            waited++;
        end
        if (!PREADY) begin
            $display("Timeout: PREADY stayed low for %0d cycles at address %h",
                     APB_TIMEOUT, addr);
            bus_stuck = 1'b1;
        end
        rdata = PRDATA;
        err   = PSLVERR;
        @(posedge PCLK);
        #1;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic drive_strobe(input logic [31:0] mask);
        irq_src = mask[NUM_SRC:1];
        @(posedge PCLK);
        #1;
        irq_src = '0;
    endtask

    // Waits for the expected levels, gives up after IRQ_TIMEOUT cycles
    task automatic sample_irq(input logic [1:0] want, output logic [1:0] got);
        int waited;
        waited = 0;
        #2;
        while ({irq_external_pending, irq_out} !== want && waited < IRQ_TIMEOUT) begin
            @(posedge PCLK);
            #3;
            waited++;
        end
        if ({irq_external_pending, irq_out} !== want)
            $display("Interrupt outputs did not reach the expected levels within %0d cycles",
                     IRQ_TIMEOUT);
        got = {irq_external_pending, irq_out};
        @(posedge PCLK);
        #1;
    endtask

    task automatic build_table();
        int          rand_ids  [5];
        prio_t       rand_prio [5];
        bit          taken     [5];
        logic [31:0] rand_mask;
        logic [31:0] tie_mask;
        int          pick;
        rand_ids  = '{2, 7, 11, 19, 26};   // Ascending, so ties favor the earlier entry
        rand_mask = '0;
        tie_mask  = bit_of(4) | bit_of(9) | bit_of(20);

        expect_read(prio_addr(1), 32'h0, 1'b0);
        expect_read(prio_addr(NUM_SRC), 32'h0, 1'b0);
        expect_read(ADDR_PENDING, 32'h0, 1'b0);
        expect_read(ADDR_ENABLE, 32'h0, 1'b0);
        expect_read(ADDR_THRESHOLD, 32'h0, 1'b0);
        expect_read(ADDR_CLAIM, 32'h0, 1'b0);
        expect_irq(1'b0, 1'b0);
        close_test("reset values");

        queue_write(prio_addr(3), 32'hFFFF_FFFD, 1'b0);
        expect_read(prio_addr(3), 32'h5, 1'b0);            // Masked to 3 bits
        queue_write(ADDR_ENABLE, 32'h5555_5555, 1'b0);
        expect_read(ADDR_ENABLE, 32'h5555_5554, 1'b0);     // Bit 0 forced low
        queue_write(ADDR_THRESHOLD, 32'h0000_00FA, 1'b0);
        expect_read(ADDR_THRESHOLD, 32'h2, 1'b0);
        queue_write(prio_addr(0), 32'h7, 1'b0);
        expect_read(prio_addr(0), 32'h0, 1'b0);
        queue_write(32'h0000_3000, 32'hFFFF_FFFF, 1'b1);    // Unmapped
        expect_read(32'h0000_3000, 32'h0, 1'b1);
        queue_write(32'h0000_000E, 32'hFFFF_FFFF, 1'b1);    // Misaligned
        queue_write(ADDR_PENDING, 32'hFFFF_FFFF, 1'b1);     // Read only
        expect_read(prio_addr(3), 32'h5, 1'b0);
        expect_read(ADDR_ENABLE, 32'h5555_5554, 1'b0);
        expect_read(ADDR_THRESHOLD, 32'h2, 1'b0);
        expect_read(ADDR_PENDING, 32'h0, 1'b0);
        queue_write(prio_addr(3), 32'h0, 1'b0);
        queue_write(ADDR_ENABLE, 32'h0, 1'b0);
        queue_write(ADDR_THRESHOLD, 32'h0, 1'b0);
        close_test("register access");

        set_trap(1'b1);
        strobe_src(bit_of(5));
        expect_read(ADDR_PENDING, bit_of(5), 1'b0);
        expect_irq(1'b0, 1'b0);                             // Priority 0, disabled
        queue_write(prio_addr(5), 32'h3, 1'b0);
        wait_cycles(2);
        expect_irq(1'b0, 1'b0);                             // Still disabled
        queue_write(ADDR_ENABLE, bit_of(5), 1'b0);
        expect_irq(1'b1, 1'b1);
        queue_write(ADDR_THRESHOLD, 32'h3, 1'b0);           // Equal to priority
        wait_cycles(2);
        expect_irq(1'b0, 1'b0);
        queue_write(ADDR_THRESHOLD, 32'h6, 1'b0);
        wait_cycles(2);
        expect_irq(1'b0, 1'b0);
        queue_write(ADDR_THRESHOLD, 32'h2, 1'b0);
        expect_irq(1'b1, 1'b1);
        expect_read(ADDR_CLAIM, 32'd5, 1'b0);
        queue_write(ADDR_CLAIM, 32'd5, 1'b0);
        expect_read(ADDR_PENDING, 32'h0, 1'b0);
        wait_cycles(2);
        expect_irq(1'b0, 1'b0);
        queue_write(ADDR_THRESHOLD, 32'h0, 1'b0);
        close_test("pending and eligibility");

        for (int k = 0; k < 5; k++) begin
            rand_prio[k] = prio_t'(1 + ($unsigned($random(seed)) % 7));
            taken[k]     = 1'b0;
            rand_mask    = rand_mask | bit_of(rand_ids[k]);
            queue_write(prio_addr(rand_ids[k]), 32'(rand_prio[k]), 1'b0);
        end
        queue_write(ADDR_ENABLE, rand_mask, 1'b0);
        strobe_src(rand_mask);
        expect_read(ADDR_PENDING, rand_mask, 1'b0);
        expect_irq(1'b1, 1'b1);
        // Expected claim order, highest priority first
        for (int n = 0; n < 5; n++) begin
            pick = -1;
            for (int k = 0; k < 5; k++) begin
                if (!taken[k]) begin
                    if (pick < 0)
                        pick = k;
                    else if (rand_prio[k] > rand_prio[pick])
                        pick = k;
                end
            end
            taken[pick] = 1'b1;
            expect_read(ADDR_CLAIM, 32'(rand_ids[pick]), 1'b0);
            queue_write(ADDR_CLAIM, 32'(rand_ids[pick]), 1'b0);
        end
        expect_read(ADDR_CLAIM, 32'h0, 1'b0);
        queue_write(prio_addr(4), 32'h6, 1'b0);
        queue_write(prio_addr(9), 32'h6, 1'b0);
        queue_write(prio_addr(20), 32'h6, 1'b0);
        queue_write(ADDR_ENABLE, tie_mask, 1'b0);
        strobe_src(tie_mask);
        expect_read(ADDR_CLAIM, 32'd4, 1'b0);
        queue_write(ADDR_CLAIM, 32'd4, 1'b0);
        expect_read(ADDR_CLAIM, 32'd9, 1'b0);
        queue_write(ADDR_CLAIM, 32'd9, 1'b0);
        expect_read(ADDR_CLAIM, 32'd20, 1'b0);
        queue_write(ADDR_CLAIM, 32'd20, 1'b0);
        expect_read(ADDR_CLAIM, 32'h0, 1'b0);
        close_test("arbitration");

        queue_write(prio_addr(10), 32'h5, 1'b0);
        queue_write(prio_addr(12), 32'h2, 1'b0);
        queue_write(ADDR_ENABLE, bit_of(10) | bit_of(12), 1'b0);
        queue_write(ADDR_THRESHOLD, 32'h1, 1'b0);
        strobe_src(bit_of(10) | bit_of(12));
        expect_irq(1'b1, 1'b1);
        expect_read(ADDR_CLAIM, 32'd10, 1'b0);
        expect_read(ADDR_PENDING, bit_of(12), 1'b0);
        wait_cycles(2);
        expect_irq(1'b0, 1'b1);                             // 12 waits behind active 10
        queue_write(ADDR_CLAIM, 32'd12, 1'b0);              // Pending, not active
        queue_write(ADDR_CLAIM, 32'd3, 1'b0);
        wait_cycles(2);
        expect_irq(1'b0, 1'b1);
        expect_read(ADDR_PENDING, bit_of(12), 1'b0);
        queue_write(ADDR_CLAIM, 32'd10, 1'b0);
        expect_irq(1'b1, 1'b1);
        expect_read(ADDR_CLAIM, 32'd12, 1'b0);
        queue_write(ADDR_CLAIM, 32'd12, 1'b0);
        expect_read(ADDR_CLAIM, 32'h0, 1'b0);
        wait_cycles(2);
        expect_irq(1'b0, 1'b0);
        close_test("claim and complete");

        set_trap(1'b0);
        queue_write(prio_addr(15), 32'h4, 1'b0);
        queue_write(ADDR_ENABLE, bit_of(15), 1'b0);
        queue_write(ADDR_THRESHOLD, 32'h0, 1'b0);
        strobe_src(bit_of(15));
        wait_cycles(3);
        expect_irq(1'b0, 1'b1);
        set_trap(1'b1);
        expect_irq(1'b1, 1'b1);
        expect_read(ADDR_CLAIM, 32'd15, 1'b0);
        queue_write(ADDR_CLAIM, 32'd15, 1'b0);
        wait_cycles(2);
        expect_irq(1'b0, 1'b0);
        close_test("trap_en low");
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        logic [1:0]  want;
        logic [1:0]  irq_got;
        int          base;
        int          tnum;
        errors    = 0;
        checks    = 0;
        base      = 0;
        bus_stuck = 1'b0;
        seed      = 32'hbaf5a018;
        PRESETn   = 1'b0;
        irq_src   = '0;
        trap_en   = 1'b0;
        PSEL      = 1'b0;
        PENABLE   = 1'b0;
        PWRITE    = 1'b0;
        PADDR     = '0;
        PWDATA    = '0;
        build_table();
        repeat (3) @(posedge PCLK);
        #1;
        PRESETn = 1'b1;

        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                OP_WRITE: begin
                    apb_access(1'b1, addr_q[i], data_q[i], rdata, err);
                    checks++;
                    if (err !== err_q[i]) begin
                        errors++;
                        $display("CHECK FAILED time=%0t signal=PSLVERR expected=%b actual=%b",
                                 $time, err_q[i], err);
                    end
                end
                OP_READ: begin
                    apb_access(1'b0, addr_q[i], 32'h0, rdata, err);
                    checks += 2;
                    if (rdata !== exp_q[i]) begin
                        errors++;
                        $display("CHECK FAILED time=%0t signal=PRDATA expected=%h actual=%h",
                                 $time, exp_q[i], rdata);
                    end
                    if (err !== err_q[i]) begin
                        errors++;
                        $display("CHECK FAILED time=%0t signal=PSLVERR expected=%b actual=%b",
                                 $time, err_q[i], err);
                    end
                end
                OP_STROBE: drive_strobe(data_q[i]);
                OP_IRQ: begin
                    want = exp_q[i][1:0];
                    sample_irq(want, irq_got);
                    checks += 2;
                    if (irq_got[0] !== want[0]) begin
                        errors++;
                        $display("CHECK FAILED time=%0t signal=irq_out expected=%b actual=%b",
                                 $time, want[0], irq_got[0]);
                    end
                    if (irq_got[1] !== want[1]) begin
                        errors++;
                        $display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b",
                                 $time, "irq_external_pending", want[1], irq_got[1]);
                    end
                end
                OP_IDLE: begin
                    repeat (data_q[i]) @(posedge PCLK);
                    #1;
                end
                OP_TRAP: trap_en = data_q[i][0];
                OP_END: begin
                    tnum = int'(data_q[i]);
                    $display("Test %0d %s: %0d errors", tnum + 1, name_q[tnum], errors - base);
                    base = errors;
                end
                default: ;
            endcase
            if (bus_stuck)
                break;
        end

        $display("Checks: %0d, errors: %0d, bus timeout: %0d", checks, errors, bus_stuck);
        if (errors == 0 && !bus_stuck) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/plic_top.sv
/*
  Interrupt controller top for one hart, configured over APB.
  NUM_SRC may be 1 to 31; source 0 is reserved and has no input.
  PREADY is always high and PSTRB is not present.
*/
`timescale 1ns/1ps
`default_nettype none

module plic_top import plic_pkg::*; #(
    parameter int NUM_SRC = 31
) (
    input  wire             PCLK,
    input  wire             PRESETn,
    input  wire [NUM_SRC:1] irq_src,
    input  wire             trap_en,
    output logic            irq_out,
    output logic            irq_external_pending,
    input  wire             PSEL,
    input  wire             PENABLE,
    input  wire             PWRITE,
    input  wire [31:0]      PADDR,
    input  wire [31:0]      PWDATA,
    output logic [31:0]     PRDATA,
    output logic            PREADY,
    output logic            PSLVERR
);

    prio_t            prio_vec [1:NUM_SRC];
    logic [NUM_SRC:0] enable_vec;
    logic [NUM_SRC:0] pending_vec;
    prio_t            threshold;
    logic             claim_pulse;
    logic             complete_pulse;
    id_t              complete_id;
    id_t              best_id;
    prio_t            best_prio;

    plic_apb_regs #(.NUM_SRC(NUM_SRC)) u_regs (
        .PCLK           (PCLK),
        .PRESETn        (PRESETn),
        .PSEL           (PSEL),
        .PENABLE        (PENABLE),
        .PWRITE         (PWRITE),
        .PADDR          (PADDR),
        .PWDATA         (PWDATA),
        .PRDATA         (PRDATA),
        .PREADY         (PREADY),
        .PSLVERR        (PSLVERR),
        .pending_vec    (pending_vec),
        .best_id        (best_id),
        .prio_vec       (prio_vec),
        .enable_vec     (enable_vec),
        .threshold      (threshold),
        .claim_pulse    (claim_pulse),
        .complete_pulse (complete_pulse),
        .complete_id    (complete_id)
    );

    plic_gateway #(.NUM_SRC(NUM_SRC)) u_gateway (
        .PCLK        (PCLK),
        .PRESETn     (PRESETn),
        .irq_src     (irq_src),
        .claim_pulse (claim_pulse),
        .best_id     (best_id),
        .pending_vec (pending_vec)
    );

    plic_arbiter #(.NUM_SRC(NUM_SRC)) u_arbiter (
        .pending_vec          (pending_vec),
        .enable_vec           (enable_vec),
        .prio_vec             (prio_vec),
        .threshold            (threshold),
        .best_id              (best_id),
        .best_prio            (best_prio),
        .irq_external_pending (irq_external_pending)
    );

    plic_target #(.NUM_SRC(NUM_SRC)) u_target (
        .PCLK           (PCLK),
        .PRESETn        (PRESETn),
        .trap_en        (trap_en),
        .claim_pulse    (claim_pulse),
        .best_id        (best_id),
        .best_prio      (best_prio),
        .complete_pulse (complete_pulse),
        .complete_id    (complete_id),
        .irq_out        (irq_out)
    );

endmodule

`default_nettype wire

// File: rtl/plic_target.sv
/*
  Single hart context. Tracks which ids are claimed and not yet completed,
  and registers the interrupt line. irq_out is held low while any id is
  active, so only one interrupt is in service at a time. A complete of an
  id that is not active has no effect.
*/
`timescale 1ns/1ps
`default_nettype none

module plic_target import plic_pkg::*; #(
    parameter int NUM_SRC = 31
) (
    input  wire        PCLK,
    input  wire        PRESETn,
    input  wire        trap_en,
    input  wire        claim_pulse,
    input  wire id_t   best_id,
    input  wire prio_t best_prio,
    input  wire        complete_pulse,
    input  wire id_t   complete_id,
    output logic       irq_out
);

    logic [NUM_SRC:1] active;

    // Id 0 matches no bit, so its claim leaves nothing active
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            active <= '0;
        end else begin
            for (int i = 1; i <= NUM_SRC; i++) begin
                if (claim_pulse && (best_id == id_t'(i)))
                    active[i] <= 1'b1;
                else if (complete_pulse && (complete_id == id_t'(i)))
                    active[i] <= 1'b0;
            end
        end
    end

    // Uses the active state before this edge, so a claim drops irq_out one edge later
    always_ff @(posedge PCLK) begin
        if (!PRESETn)
            irq_out <= 1'b0;
        else
            irq_out <= (best_prio != '0) && !(|active) && trap_en;
    end

    // Claim at one edge, irq_out low from the edge after it
    a_irq_low_after_claim: assert property (
        @(posedge PCLK) disable iff (!PRESETn)
        (claim_pulse && (best_id != '0)) |=> ##1 !irq_out
    );

endmodule

`default_nettype wire

// File: rtl/plic_arbiter.sv
/*
  Purely combinational winner search over ids 1 to NUM_SRC.
  A candidate must be pending, enabled and strictly above the threshold.
  Ties go to the lower id. No candidate gives id 0 and priority 0.
*/
`timescale 1ns/1ps
`default_nettype none

module plic_arbiter import plic_pkg::*; #(
    parameter int NUM_SRC = 31
) (
    input  wire [NUM_SRC:0] pending_vec,
    input  wire [NUM_SRC:0] enable_vec,
    input  wire prio_t      prio_vec [1:NUM_SRC],
    input  wire prio_t      threshold,
    output id_t             best_id,
    output prio_t           best_prio,
    output logic            irq_external_pending
);

    logic [NUM_SRC:1] eligible;
    id_t              win_id;
    prio_t            win_prio;

    // Source 0 never competes
    always_comb begin
        eligible = '0;
        for (int i = 1; i <= NUM_SRC; i++) begin
            eligible[i] = pending_vec[i] && enable_vec[i] && (prio_vec[i] > threshold);
        end
    end

    always_comb begin
        win_id   = '0;
        win_prio = '0;
        // Ascending scan with strict compare keeps the lowest id on a tie
        for (int i = 1; i <= NUM_SRC; i++) begin
            if (eligible[i] && (prio_vec[i] > win_prio)) begin
                win_id   = id_t'(i);
                win_prio = prio_vec[i];
            end
        end
    end

    assign best_id   = win_id;
    assign best_prio = win_prio;

    // Feeds MEIP on the hart side
    assign irq_external_pending = (win_prio != '0);

endmodule

`default_nettype wire

// File: rtl/plic_gateway.sv
/*
  Pending bits, one per source. A source that is high on an edge sets its
  bit; a claim of that id on the same edge wins and clears it. Strobes
  while a bit is already pending are absorbed.
*/
`timescale 1ns/1ps
`default_nettype none

module plic_gateway import plic_pkg::*; #(
    parameter int NUM_SRC = 31
) (
    input  wire              PCLK,
    input  wire              PRESETn,
    input  wire [NUM_SRC:1]  irq_src,
    input  wire              claim_pulse,
    input  wire id_t         best_id,
    output logic [NUM_SRC:0] pending_vec
);

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            pending_vec <= '0;
        end else begin
            pending_vec[0] <= 1'b0;   // Reserved id
            for (int i = 1; i <= NUM_SRC; i++) begin
                if (claim_pulse && (best_id == id_t'(i)))
                    pending_vec[i] <= 1'b0;
                else if (irq_src[i])
                    pending_vec[i] <= 1'b1;
            end
        end
    end

    // A nonzero claim always targets a pending source
    a_claim_hits_pending: assert property (
        @(posedge PCLK) disable iff (!PRESETn)
        (claim_pulse && (best_id != '0)) |-> pending_vec[best_id]
    );

endmodule

`default_nettype wire

// File: rtl/plic_apb_regs.sv
/*
  APB slave with zero wait states; PREADY is tied high and PSTRB is not
  supported, so every write is a full word. PRDATA is combinational.
  Writes to the pending word or to a priority id above NUM_SRC raise
  PSLVERR and are dropped, as are accesses outside the map.
*/
`timescale 1ns/1ps
`default_nettype none

module plic_apb_regs import plic_pkg::*; #(
    parameter int NUM_SRC = 31
) (
    input  wire              PCLK,
    input  wire              PRESETn,
    input  wire              PSEL,
    input  wire              PENABLE,
    input  wire              PWRITE,
    input  wire [31:0]       PADDR,
    input  wire [31:0]       PWDATA,
    output logic [31:0]      PRDATA,
    output logic             PREADY,
    output logic             PSLVERR,
    input  wire [NUM_SRC:0]  pending_vec,
    input  wire id_t         best_id,
    output prio_t            prio_vec [1:NUM_SRC],
    output logic [NUM_SRC:0] enable_vec,
    output prio_t            threshold,
    output logic             claim_pulse,
    output logic             complete_pulse,
    output id_t              complete_id
);

    logic        access;
    logic        hit_prio, hit_pend, hit_en, hit_thr, hit_claim;
    logic        mapped;
    logic        wr_bad;
    logic        wr_ok;
    id_t         prio_idx;
    logic        prio_valid;
    logic [31:0] rdata;

    assign access = PSEL && PENABLE;   // Second APB phase

    // Priority window holds one word per possible id
    assign prio_idx   = PADDR[ID_W+1:2];
    assign hit_prio   = (PADDR[31:ID_W+2] == ADDR_PRIO_BASE[31:ID_W+2]) &&
                        (PADDR[1:0] == 2'b00);
    assign prio_valid = (prio_idx != '0) && (int'(prio_idx) <= NUM_SRC);

    assign hit_pend  = (PADDR == ADDR_PENDING);
    assign hit_en    = (PADDR == ADDR_ENABLE);
    assign hit_thr   = (PADDR == ADDR_THRESHOLD);
    assign hit_claim = (PADDR == ADDR_CLAIM);
    assign mapped    = hit_prio || hit_pend || hit_en || hit_thr || hit_claim;

    // Id 0 priority is silently ignored, ids past NUM_SRC are an error
    assign wr_bad = PWRITE && (hit_pend || (hit_prio && (prio_idx != '0) && !prio_valid));

    assign PREADY  = 1'b1;
    assign PSLVERR = access && (!mapped || wr_bad);
    assign wr_ok   = access && PWRITE && !PSLVERR;

    assign claim_pulse    = access && !PWRITE && hit_claim;
    assign complete_pulse = access && PWRITE && hit_claim;
    assign complete_id    = PWDATA[ID_W-1:0];

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            for (int i = 1; i <= NUM_SRC; i++) begin
                prio_vec[i] <= '0;
            end
            enable_vec <= '0;
            threshold  <= '0;
        end else if (wr_ok) begin
            if (hit_prio) begin
                for (int i = 1; i <= NUM_SRC; i++) begin
                    if (prio_idx == id_t'(i))
                        prio_vec[i] <= PWDATA[PRIO_W-1:0];
                end
            end
            if (hit_en)
                enable_vec <= {PWDATA[NUM_SRC:1], 1'b0};   // Source 0 never enabled
            if (hit_thr)
                threshold <= PWDATA[PRIO_W-1:0];
        end
    end

    // Read mux, unused bits stay zero
    always_comb begin
        rdata = '0;
        if (hit_prio) begin
            for (int i = 1; i <= NUM_SRC; i++) begin
                if (prio_idx == id_t'(i))
                    rdata[PRIO_W-1:0] = prio_vec[i];
            end
        end else if (hit_pend) begin
            rdata[NUM_SRC:0] = pending_vec;
        end else if (hit_en) begin
            rdata[NUM_SRC:0] = enable_vec;
        end else if (hit_thr) begin
            rdata[PRIO_W-1:0] = threshold;
        end else if (hit_claim) begin
            rdata[ID_W-1:0] = best_id;   // Winner at the time of the read
        end
    end

    assign PRDATA = rdata;

    // Bus master must hold PSEL through the access phase
    a_penable_with_psel: assert property (
        @(posedge PCLK) disable iff (!PRESETn) $rose(PENABLE) |-> PSEL
    );

    // Claim and complete events last exactly one access cycle
    a_claim_complete_single: assert property (
        @(posedge PCLK) disable iff (!PRESETn)
        (claim_pulse || complete_pulse) |=> !(claim_pulse || complete_pulse)
    );

endmodule

`default_nettype wire

// File: rtl/plic_pkg.sv
/*
  Shared widths, types and the register map of the interrupt controller.
  Ids are 5 bits wide, so at most 31 sources fit in a single pending and
  enable word. Id 0 and priority 0 both mean "none".
*/
`default_nettype none

package plic_pkg;

    localparam int PRIO_W = 3;      // Priority and threshold width
    localparam int ID_W   = 5;      // Up to id 31

    typedef logic [PRIO_W-1:0] prio_t;
    typedef logic [ID_W-1:0]   id_t;

    // Byte offsets on the APB side
    localparam logic [31:0] ADDR_PRIO_BASE = 32'h0000_0000;    // Id n at base + 4*n
    localparam logic [31:0] ADDR_PENDING   = 32'h0000_1000;    // Read only
    localparam logic [31:0] ADDR_ENABLE    = 32'h0000_2000;
    localparam logic [31:0] ADDR_THRESHOLD = 32'h0020_0000;
    localparam logic [31:0] ADDR_CLAIM     = 32'h0020_0004;    // Read claims, write completes

endpackage

`default_nettype wire
